// File: axi_dc_pkg.sv
`default_nettype none

package axi_dc_pkg;

	localparam int BUFFER_WIDTH    = 8;   // ring slots.
	localparam int MAX_OUTSTANDING = 2;
	localparam int BEAT_BYTES      = 4;   // incr burst, 4-byte beats.

	localparam int ADDR_WIDTH    = 32;
	localparam int DATA_WIDTH    = 32;
	localparam int LEN_WIDTH     = 8;
	localparam int RESP_WIDTH    = 2;
	localparam int OUT_CNT_WIDTH = 2;
	localparam int BEAT_WIDTH    = ADDR_WIDTH + DATA_WIDTH + 1;

	typedef logic [ADDR_WIDTH-1:0]    addr_t;
	typedef logic [DATA_WIDTH-1:0]    data_t;
	typedef logic [LEN_WIDTH-1:0]     len_t;    // beats minus one.
	typedef logic [RESP_WIDTH-1:0]    resp_t;
	typedef logic [BUFFER_WIDTH-1:0]  ring_t;   // one-hot.
	typedef logic [BEAT_WIDTH-1:0]    beat_t;   // {addr, data, last}.
	typedef logic [OUT_CNT_WIDTH-1:0] out_cnt_t;

	typedef enum logic [1:0] {IDLE, BURST, HOLD} burst_state_t;

	localparam ring_t RING_RESET = ring_t'(1);

endpackage

`default_nettype wire

// File: axi_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

// beat stream from the burst controller into the crossing.
interface axi_beat_if;

	logic              valid;
	logic              ready;
	axi_dc_pkg::addr_t addr;
	axi_dc_pkg::data_t data;
	logic              last;

	modport source (
		output valid,
		output addr,
		output data,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  addr,
		input  data,
		input  last,
		output ready
	);

endinterface

`default_nettype wire

// File: dc_token_ring_fifo_din.sv
`timescale 1ns/1ps
`default_nettype none

module dc_token_ring_fifo_din #(
	parameter int WIDTH = axi_dc_pkg::BEAT_WIDTH
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              valid_i,
	output logic              ready_o,
	input  logic [WIDTH-1:0]  data_i,
	output axi_dc_pkg::ring_t write_token_o,
	input  axi_dc_pkg::ring_t read_pointer_i,
	output logic [WIDTH-1:0]  data_async_o
);

	localparam int BW = axi_dc_pkg::BUFFER_WIDTH;

	logic [WIDTH-1:0]  buffer_q [BW];
	axi_dc_pkg::ring_t write_token_q;
	axi_dc_pkg::ring_t next_token;
	axi_dc_pkg::ring_t rp_meta_q, rp_sync_q;
	logic              push;

	assign next_token    = {write_token_q[BW-2:0], write_token_q[BW-1]};
	assign ready_o       = (next_token != rp_sync_q); // one slot kept free.
	assign push          = valid_i && ready_o;
	assign write_token_o = write_token_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			write_token_q <= axi_dc_pkg::RING_RESET;
			rp_meta_q     <= axi_dc_pkg::RING_RESET;
			rp_sync_q     <= axi_dc_pkg::RING_RESET;
		end else begin
			rp_meta_q <= read_pointer_i;
			rp_sync_q <= rp_meta_q;
			if (push)
				write_token_q <= next_token;
		end
	end

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < BW; i++) begin
			if (push && write_token_q[i])
				buffer_q[i] <= data_i;
		end
	end

	// slot picked by the far side's pointer, read without a clock.
	always_comb begin
		data_async_o = '0;
		for (int i = 0; i < BW; i++) begin
			if (read_pointer_i[i])
				data_async_o = data_async_o | buffer_q[i];
		end
	end

endmodule

`default_nettype wire

// File: dc_token_ring_fifo_dout.sv
`timescale 1ns/1ps
`default_nettype none

module dc_token_ring_fifo_dout #(
	parameter int WIDTH = axi_dc_pkg::BEAT_WIDTH
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	output logic              valid_o,
	input  logic              ready_i,
	output logic [WIDTH-1:0]  data_o,
	input  axi_dc_pkg::ring_t write_token_i,
	output axi_dc_pkg::ring_t read_pointer_o,
	input  logic [WIDTH-1:0]  data_async_i
);

	localparam int BW = axi_dc_pkg::BUFFER_WIDTH;

	axi_dc_pkg::ring_t read_pointer_q;
	axi_dc_pkg::ring_t wt_meta_q, wt_sync_q;
	logic              pop;

	// entry present while the pointer trails the token.
	assign valid_o        = (wt_sync_q != read_pointer_q);
	assign pop            = valid_o && ready_i;
	assign read_pointer_o = read_pointer_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			read_pointer_q <= axi_dc_pkg::RING_RESET;
			wt_meta_q      <= axi_dc_pkg::RING_RESET;
			wt_sync_q      <= axi_dc_pkg::RING_RESET;
		end else begin
			wt_meta_q <= write_token_i;
			wt_sync_q <= wt_meta_q;
			if (pop)
				read_pointer_q <= {read_pointer_q[BW-2:0], read_pointer_q[BW-1]};
		end
	end

	// the slot under the pointer is stable once the token is seen here,
	// an empty ring shows zeros.
	always_comb begin
		if (valid_o)
			data_o = data_async_i;
		else
			data_o = '0;
	end

endmodule

`default_nettype wire

// File: axi_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_ctrl (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              s_aw_valid_i,
	input  axi_dc_pkg::addr_t s_aw_addr_i,
	input  axi_dc_pkg::len_t  s_aw_len_i,
	output logic              s_aw_ready_o,
	input  logic              s_w_valid_i,
	input  axi_dc_pkg::data_t s_w_data_i,
	output logic              s_w_ready_o,
	output logic              cnt_load_o,
	output logic              cnt_step_o,
	input  logic              cnt_final_i,
	input  axi_dc_pkg::addr_t cnt_addr_i,
	input  logic              cnt_full_i,
	axi_beat_if.source        beat
);

	axi_dc_pkg::burst_state_t state_q, state_d;
	axi_dc_pkg::data_t        hold_data_q;

	assign s_aw_ready_o = (state_q == axi_dc_pkg::IDLE) && !cnt_full_i;
	assign cnt_load_o   = s_aw_valid_i && s_aw_ready_o;
	assign cnt_step_o   = beat.valid && beat.ready;

	always_comb begin
		beat.valid  = 1'b0;
		beat.addr   = cnt_addr_i;
		beat.data   = s_w_data_i;
		beat.last   = cnt_final_i;
		s_w_ready_o = 1'b0;
		state_d     = state_q;
		case (state_q)
			axi_dc_pkg::IDLE: begin
				if (cnt_load_o)
					state_d = axi_dc_pkg::BURST;
			end
			axi_dc_pkg::BURST: begin
				beat.valid  = s_w_valid_i;
				s_w_ready_o = beat.ready;
				if (s_w_valid_i && !beat.ready)
					state_d = axi_dc_pkg::HOLD; // ring full.
				else if (s_w_valid_i && beat.ready && cnt_final_i)
					state_d = axi_dc_pkg::IDLE;
			end
			axi_dc_pkg::HOLD: begin
				beat.valid  = 1'b1;
				beat.data   = hold_data_q;
				s_w_ready_o = beat.ready;
				if (beat.ready)
					state_d = cnt_final_i ? axi_dc_pkg::IDLE : axi_dc_pkg::BURST;
			end
			default: state_d = axi_dc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			state_q <= axi_dc_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk_i) begin
		if (state_q == axi_dc_pkg::BURST)
			hold_data_q <= s_w_data_i; // stalled word kept for hold.
	end

endmodule

`default_nettype wire

// File: axi_burst_counters.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_counters (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              load_i,
	input  axi_dc_pkg::addr_t addr_i,
	input  axi_dc_pkg::len_t  len_i,
	input  logic              step_i,
	input  logic              resp_done_i,
	output axi_dc_pkg::addr_t beat_addr_o,
	output logic              final_o,
	output logic              full_o
);

	axi_dc_pkg::addr_t    addr_q;
	axi_dc_pkg::len_t     remain_q;
	axi_dc_pkg::out_cnt_t out_cnt_q;

	assign beat_addr_o = addr_q;
	assign final_o     = (remain_q == '0);
	assign full_o      = (out_cnt_q == axi_dc_pkg::out_cnt_t'(axi_dc_pkg::MAX_OUTSTANDING));

	always_ff @(posedge clk_i) begin
		if (load_i)
			addr_q <= addr_i;
		else if (step_i)
			addr_q <= addr_q + axi_dc_pkg::addr_t'(axi_dc_pkg::BEAT_BYTES);
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			remain_q <= '0;
		end else if (load_i) begin
			remain_q <= len_i;
		end else if (step_i && !final_o) begin
			remain_q <= remain_q - 1'b1;
		end
	end

	// bursts accepted without a response back yet.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_cnt_q <= '0;
		end else begin
			case ({load_i, resp_done_i})
				2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
				2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
				default: out_cnt_q <= out_cnt_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: axi_single_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axi_single_slice (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              valid_i,
	output logic              ready_o,
	input  axi_dc_pkg::resp_t data_i,
	output logic              valid_o,
	input  logic              ready_i,
	output axi_dc_pkg::resp_t data_o
);

	logic              full_q;
	axi_dc_pkg::resp_t data_q;

	assign ready_o = !full_q || ready_i; // empty or draining now.
	assign valid_o = full_q;
	assign data_o  = data_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			full_q <= 1'b0;
		else if (ready_o)
			full_q <= valid_i;
	end

	always_ff @(posedge clk_i) begin
		if (valid_i && ready_o)
			data_q <= data_i;
	end

endmodule

`default_nettype wire

// File: axi_dc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_dc_bridge (
	input  logic              clk_i,
	input  logic              clk_master_i,
	input  logic              arst_n_i,
	input  logic              s_aw_valid_i,
	input  axi_dc_pkg::addr_t s_aw_addr_i,
	input  axi_dc_pkg::len_t  s_aw_len_i,
	output logic              s_aw_ready_o,
	input  logic              s_w_valid_i,
	input  axi_dc_pkg::data_t s_w_data_i,
	output logic              s_w_ready_o,
	output logic              s_b_valid_o,
	output axi_dc_pkg::resp_t s_b_resp_o,
	input  logic              s_b_ready_i,
	output logic              m_beat_valid_o,
	output axi_dc_pkg::addr_t m_beat_addr_o,
	output axi_dc_pkg::data_t m_beat_data_o,
	output logic              m_beat_last_o,
	input  logic              m_beat_ready_i,
	input  logic              m_b_valid_i,
	input  axi_dc_pkg::resp_t m_b_resp_i,
	output logic              m_b_ready_o
);

	logic              cnt_load, cnt_step, cnt_final, cnt_full;
	axi_dc_pkg::addr_t cnt_addr;
	logic              resp_done;
	axi_dc_pkg::beat_t beat_in, beat_async, beat_out;
	axi_dc_pkg::ring_t beat_wtoken, beat_rptr;
	axi_dc_pkg::ring_t resp_wtoken, resp_rptr;
	axi_dc_pkg::resp_t resp_async, resp_dc;
	logic              resp_dc_valid, resp_dc_ready;

	axi_beat_if beat_if ();

	assign beat_in   = {beat_if.addr, beat_if.data, beat_if.last};
	assign {m_beat_addr_o, m_beat_data_o, m_beat_last_o} = beat_out;
	assign resp_done = s_b_valid_o && s_b_ready_i;

	axi_burst_ctrl u_ctrl (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.s_aw_valid_i(s_aw_valid_i), .s_aw_addr_i(s_aw_addr_i),
		.s_aw_len_i(s_aw_len_i), .s_aw_ready_o(s_aw_ready_o),
		.s_w_valid_i(s_w_valid_i), .s_w_data_i(s_w_data_i), .s_w_ready_o(s_w_ready_o),
		.cnt_load_o(cnt_load), .cnt_step_o(cnt_step),
		.cnt_final_i(cnt_final), .cnt_addr_i(cnt_addr), .cnt_full_i(cnt_full),
		.beat(beat_if)
	);

	axi_burst_counters u_cnt (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.load_i(cnt_load), .addr_i(s_aw_addr_i), .len_i(s_aw_len_i),
		.step_i(cnt_step), .resp_done_i(resp_done),
		.beat_addr_o(cnt_addr), .final_o(cnt_final), .full_o(cnt_full)
	);

	// beats, clk_i to clk_master_i.
	dc_token_ring_fifo_din #(.WIDTH(axi_dc_pkg::BEAT_WIDTH)) u_beat_din (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.valid_i(beat_if.valid), .ready_o(beat_if.ready), .data_i(beat_in),
		.write_token_o(beat_wtoken), .read_pointer_i(beat_rptr),
		.data_async_o(beat_async)
	);

	dc_token_ring_fifo_dout #(.WIDTH(axi_dc_pkg::BEAT_WIDTH)) u_beat_dout (
		.clk_i(clk_master_i), .arst_n_i(arst_n_i),
		.valid_o(m_beat_valid_o), .ready_i(m_beat_ready_i), .data_o(beat_out),
		.write_token_i(beat_wtoken), .read_pointer_o(beat_rptr),
		.data_async_i(beat_async)
	);

	// responses, clk_master_i back to clk_i.
	dc_token_ring_fifo_din #(.WIDTH(axi_dc_pkg::RESP_WIDTH)) u_resp_din (
		.clk_i(clk_master_i), .arst_n_i(arst_n_i),
		.valid_i(m_b_valid_i), .ready_o(m_b_ready_o), .data_i(m_b_resp_i),
		.write_token_o(resp_wtoken), .read_pointer_i(resp_rptr),
		.data_async_o(resp_async)
	);

	dc_token_ring_fifo_dout #(.WIDTH(axi_dc_pkg::RESP_WIDTH)) u_resp_dout (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.valid_o(resp_dc_valid), .ready_i(resp_dc_ready), .data_o(resp_dc),
		.write_token_i(resp_wtoken), .read_pointer_o(resp_rptr),
		.data_async_i(resp_async)
	);

	axi_single_slice u_b_slice (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.valid_i(resp_dc_valid), .ready_o(resp_dc_ready), .data_i(resp_dc),
		.valid_o(s_b_valid_o), .ready_i(s_b_ready_i), .data_o(s_b_resp_o)
	);

endmodule

`default_nettype wire

// File: tb_axi_dc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_dc_bridge;

	localparam time CLK_PERIOD  = 100;
	localparam time MCLK_PERIOD = 140;
	localparam int  MAX_BEATS   = 120;
	// a dozen master cycles per beat end to end, with margin.
	localparam time WATCHDOG    = MAX_BEATS * MCLK_PERIOD * 12;
	localparam axi_dc_pkg::resp_t OKAY   = 2'b00;
	localparam axi_dc_pkg::resp_t SLVERR = 2'b10;

	logic              clk_i = 1'b0;
	logic              clk_master_i = 1'b0;
	logic              arst_n_i;
	logic              s_aw_valid_i, s_aw_ready_o;
	axi_dc_pkg::addr_t s_aw_addr_i;
	axi_dc_pkg::len_t  s_aw_len_i;
	logic              s_w_valid_i, s_w_ready_o;
	axi_dc_pkg::data_t s_w_data_i;
	logic              s_b_valid_o, s_b_ready_i;
	axi_dc_pkg::resp_t s_b_resp_o;
	logic              m_beat_valid_o, m_beat_last_o, m_beat_ready_i;
	axi_dc_pkg::addr_t m_beat_addr_o;
	axi_dc_pkg::data_t m_beat_data_o;
	logic              m_b_valid_i, m_b_ready_o;
	axi_dc_pkg::resp_t m_b_resp_i;

	axi_dc_pkg::beat_t rx_q[$];          // beats taken at the master port.
	axi_dc_pkg::beat_t exp_q[$];
	axi_dc_pkg::resp_t resp_codes[$];    // codes the master answers with.
	axi_dc_pkg::resp_t resp_pending[$];
	axi_dc_pkg::resp_t next_code;
	logic              master_ready, resp_enable;
	int                err_cnt, chk_cnt, w_accepted;

	axi_dc_bridge uut (.*);

	always #(CLK_PERIOD/2) clk_i = ~clk_i;
	always #(MCLK_PERIOD/2) clk_master_i = ~clk_master_i;

	// downstream slave model on the master clock.
	initial begin
		m_beat_ready_i = 1'b0;
		m_b_valid_i    = 1'b0;
		m_b_resp_i     = '0;
		forever begin
			@(negedge clk_master_i);
			m_beat_ready_i = master_ready;
			m_b_valid_i    = resp_enable && (resp_pending.size() > 0);
			m_b_resp_i     = (resp_pending.size() > 0) ? resp_pending[0] : OKAY;
			#1;
			if (m_beat_valid_o && m_beat_ready_i) begin
				rx_q.push_back({m_beat_addr_o, m_beat_data_o, m_beat_last_o});
				if (m_beat_last_o) begin
					next_code = OKAY;
					if (resp_codes.size() > 0)
						next_code = resp_codes.pop_front();
					resp_pending.push_back(next_code);
				end
			end
			if (m_b_valid_i && m_b_ready_o)
				resp_pending.delete(0); // taken on the coming edge.
		end
	end

	task automatic issue_aw(input axi_dc_pkg::addr_t addr, input axi_dc_pkg::len_t len);
		s_aw_valid_i = 1'b1;
		s_aw_addr_i  = addr;
		s_aw_len_i   = len;
		#10;
		while (!s_aw_ready_o) begin
			@(negedge clk_i);
			#10;
		end
		@(negedge clk_i);
		s_aw_valid_i = 1'b0;
	endtask

	task automatic push_word(input axi_dc_pkg::data_t word);
		s_w_valid_i = 1'b1;
		s_w_data_i  = word;
		#10;
		while (!s_w_ready_o) begin
			@(negedge clk_i);
			#10;
		end
		w_accepted++;
		@(negedge clk_i);
		s_w_valid_i = 1'b0;
	endtask

	// beat k lands at start + 4k, last only on the final one.
	task automatic write_burst(input axi_dc_pkg::addr_t addr, input axi_dc_pkg::len_t len);
		axi_dc_pkg::data_t word;
		axi_dc_pkg::addr_t beat_addr;
		int                k;
		issue_aw(addr, len);
		for (k = 0; k <= int'(len); k++) begin
			word      = $urandom();
			beat_addr = addr + axi_dc_pkg::addr_t'(k * axi_dc_pkg::BEAT_BYTES);
			exp_q.push_back({beat_addr, word, (k == int'(len))});
			push_word(word);
		end
	endtask

	task automatic compare_beats(input int n);
		axi_dc_pkg::beat_t got, want;
		int                i;
		for (i = 0; i < n; i++) begin
			while (rx_q.size() == 0)
				@(negedge clk_i);
			got  = rx_q.pop_front();
			want = exp_q.pop_front();
			chk_cnt++;
			if (got !== want) begin
				err_cnt++;
				$display("[ERROR] %0t: beat %0d is %h, expected %h (addr, data, last)",
					$time, i, got, want);
			end
		end
		repeat (10) @(negedge clk_master_i);
		chk_cnt++;
		if (rx_q.size() != 0) begin
			err_cnt++;
			$display("[ERROR] %0t: %0d extra beats at the master port", $time, rx_q.size());
		end
		@(negedge clk_i);
	endtask

	task automatic take_resp(input axi_dc_pkg::resp_t expected);
		s_b_ready_i = 1'b1;
		#10;
		while (!s_b_valid_o) begin
			@(negedge clk_i);
			#10;
		end
		chk_cnt++;
		if (s_b_resp_o !== expected) begin
			err_cnt++;
			$display("[ERROR] %0t: s_b_resp_o is %b, expected %b", $time, s_b_resp_o, expected);
		end
		@(negedge clk_i);
		s_b_ready_i = 1'b0;
	endtask

	task automatic single_beat();
		write_burst(32'h0000_1000, 8'd0);
		compare_beats(1);
		take_resp(OKAY);
	endtask

	task automatic incr_burst();
		write_burst(32'h0000_2040, 8'd5);
		compare_beats(6);
		take_resp(OKAY);
	endtask

	task automatic beat_backpressure();
		master_ready = 1'b0;
		w_accepted   = 0;
		fork
			write_burst(32'h0000_3000, 8'd11);
			begin
				repeat (40) @(negedge clk_i);
				chk_cnt++;
				if (w_accepted > 7) begin
					err_cnt++;
					$display("[ERROR] %0t: %0d beats accepted while stalled, at most 7 expected",
						$time, w_accepted);
				end
				master_ready = 1'b1;
			end
		join
		compare_beats(12);
		take_resp(OKAY);
	endtask

	task automatic resp_order();
		axi_dc_pkg::resp_t held;
		resp_codes.push_back(OKAY);
		resp_codes.push_back(SLVERR);
		write_burst(32'h0000_4000, 8'd1);
		write_burst(32'h0000_5000, 8'd0);
		compare_beats(3);
		#10;
		while (!s_b_valid_o) begin
			@(negedge clk_i);
			#10;
		end
		held = s_b_resp_o;
		repeat (10) begin
			@(negedge clk_i);
			#10;
			chk_cnt++;
			if (!s_b_valid_o || s_b_resp_o !== held) begin
				err_cnt++;
				$display("[ERROR] %0t: stalled response changed to valid %b code %b, expected 1 %b",
					$time, s_b_valid_o, s_b_resp_o, held);
			end
		end
		@(negedge clk_i);
		take_resp(OKAY);
		take_resp(SLVERR);
	endtask

	task automatic outstanding_limit();
		resp_enable = 1'b0; // responses parked at the master.
		write_burst(32'h0000_6000, 8'd0);
		write_burst(32'h0000_7000, 8'd0);
		compare_beats(2);
		repeat (10) begin
			#10;
			chk_cnt++;
			if (s_aw_ready_o !== 1'b0) begin
				err_cnt++;
				$display("[ERROR] %0t: s_aw_ready_o high with two bursts outstanding", $time);
			end
			@(negedge clk_i);
		end
		resp_enable = 1'b1;
		take_resp(OKAY);
		#10;
		chk_cnt++;
		if (s_aw_ready_o !== 1'b1) begin
			err_cnt++;
			$display("[ERROR] %0t: s_aw_ready_o still low after a response", $time);
		end
		@(negedge clk_i);
		take_resp(OKAY);
	endtask

	initial begin
		#WATCHDOG;
		$display("watchdog expired at %0t, the DUT stopped making progress", $time);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(50));
		err_cnt      = 0;
		chk_cnt      = 0;
		w_accepted   = 0;
		arst_n_i     = 1'b0;
		s_aw_valid_i = 1'b0;
		s_aw_addr_i  = '0;
		s_aw_len_i   = '0;
		s_w_valid_i  = 1'b0;
		s_w_data_i   = '0;
		s_b_ready_i  = 1'b0;
		master_ready = 1'b1;
		resp_enable  = 1'b1;
		repeat (4) @(negedge clk_i);
		arst_n_i = 1'b1;
		#10;
		chk_cnt++;
		if (s_aw_ready_o !== 1'b1 || s_w_ready_o !== 1'b0 || s_b_valid_o !== 1'b0 ||
			m_beat_valid_o !== 1'b0 || m_b_ready_o !== 1'b1) begin
			err_cnt++;
			$display("[ERROR] %0t: wrong state after reset", $time);
		end
		@(negedge clk_i);
		single_beat();
		incr_burst();
		beat_backpressure();
		resp_order();
		outstanding_limit();
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
axi_dc_pkg.sv
axi_beat_if.sv
dc_token_ring_fifo_din.sv
dc_token_ring_fifo_dout.sv
axi_burst_ctrl.sv
axi_burst_counters.sv
axi_single_slice.sv
axi_dc_bridge.sv
tb_axi_dc_bridge.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module tb_axi_dc_bridge -f flist.f -o sim_tb &&
	./obj_dir/sim_tb | tee /dev/stderr | grep -qx "TEST PASSED" &&
	exit 0 || exit 1
